/* logic/l2_pkg.sv */
// Shared geometry, state and AXI read-channel types for the L2 read cache
// Geometry is fixed here; every module derives its widths from these values
// Address split assumes power-of-two beats, sets and ways
package l2_pkg;

	// Bus and line geometry
	localparam int ADDR_W     = 32;
	localparam int DATA_W     = 64;
	localparam int BEAT_BYTES = 8;
	localparam int LINE_BEATS = 16;
	localparam int WAYS       = 4;
	localparam int SETS       = 32;

	// Derived field widths
	localparam int OFFS_W = $clog2(BEAT_BYTES);
	localparam int BEAT_W = $clog2(LINE_BEATS);
	localparam int SET_W  = $clog2(SETS);
	localparam int WAY_W  = $clog2(WAYS);
	localparam int TAG_W  = ADDR_W - SET_W - BEAT_W - OFFS_W;

	// Victim LFSR reset value, must be nonzero
	localparam logic [15:0] LFSR_SEED = 16'hace1;

	// Controller states
	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		REFILL,
		RESPOND,
		FENCE
	} l2_state_e;

	// AXI burst encodings, WRAP not supported
	typedef enum logic [1:0] {
		FIXED = 2'b00,
		INCR  = 2'b01
	} axi_burst_e;

	// AR channel payload
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [7:0]        len;
		axi_burst_e        burst;
	} axi_ar_t;

	// R channel payload
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
		logic              last;
	} axi_r_t;

	// Address view: tag | set | beat in line | byte in beat
	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		logic [SET_W-1:0]  set;
		logic [BEAT_W-1:0] beat;
		logic [OFFS_W-1:0] offs;
	} l2_addr_t;

endpackage

/* logic/l2_ctrl.sv */
// L2 controller FSM; holds the request sampled in IDLE
// The request is only accepted upstream on a lookup hit; a miss refills
// and then looks up again, so the requester must keep AR stable meanwhile
module l2_ctrl (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            up_ar_valid,
	input  l2_pkg::axi_ar_t up_ar,
	input  logic            fence_req,
	input  logic            hit,
	input  logic            refill_done,
	input  logic            resp_done,
	output logic            up_ar_ready,
	output l2_pkg::axi_ar_t req,
	output logic            lookup,
	output logic            alloc,
	output logic            refill_start,
	output logic            resp_start,
	output logic            inval_all,
	output logic            fence_done
);
	import l2_pkg::*;

	l2_state_e state_q;
	l2_state_e state_d;

	// Next state
	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				// Fence wins over a pending read
				if (fence_req) begin
					state_d = FENCE;
				end else if (up_ar_valid) begin
					state_d = LOOKUP;
				end
			end
			LOOKUP: begin
				state_d = hit ? RESPOND : REFILL;
			end
			REFILL: begin
				// Back to IDLE, the same request then hits
				if (refill_done) begin
					state_d = IDLE;
				end
			end
			RESPOND: begin
				if (resp_done) begin
					state_d = IDLE;
				end
			end
			FENCE: begin
				state_d = IDLE;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Request copy, refreshed each time IDLE sees a read
	always_ff @(posedge clk) begin
		if (state_q == IDLE && !fence_req && up_ar_valid) begin
			req <= up_ar;
		end
	end

	// LOOKUP lasts one cycle, so every command below is a single pulse
	assign lookup       = (state_q == LOOKUP);
	assign resp_start   = lookup & hit;
	assign alloc        = lookup & ~hit;
	assign refill_start = alloc;

	// AR handshake completes only on a hit
	assign up_ar_ready  = resp_start;

	// One cycle of FENCE clears the valid bits and acknowledges
	assign inval_all    = (state_q == FENCE);
	assign fence_done   = inval_all;

endmodule

/* logic/l2_tag_store.sv */
// Tag and valid arrays with a combinational compare over all ways of a set
// Tags have no reset; the valid bits alone qualify a match
// At most one way can match, since a line is only allocated on a miss
module l2_tag_store (
	input  logic                     clk,
	input  logic                     arst_n,
	input  l2_pkg::l2_addr_t         addr,
	input  logic                     alloc,
	input  logic [l2_pkg::WAY_W-1:0] alloc_way,
	input  logic                     inval_all,
	output logic                     hit,
	output logic [l2_pkg::WAY_W-1:0] hit_way,
	output logic [l2_pkg::WAYS-1:0]  set_valid
);
	import l2_pkg::*;

	logic [TAG_W-1:0]            tags [SETS][WAYS];
	logic [SETS-1:0][WAYS-1:0]   valid_q;
	logic [WAYS-1:0]             match;

	// Per-way compare in the addressed set
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			match[w] = valid_q[addr.set][w] && (tags[addr.set][w] == addr.tag);
		end
	end

	// Encode the matching way
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (match[w]) begin
				hit_way = WAY_W'(w);
			end
		end
	end

	assign hit       = |match;
	assign set_valid = valid_q[addr.set];

	// Tag write on allocation
	always_ff @(posedge clk) begin
		if (alloc) begin
			tags[addr.set][alloc_way] <= addr.tag;
		end
	end

	// Valid set early so the line hits while it is still refilling
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
		end else if (inval_all) begin
			valid_q <= '0;
		end else if (alloc) begin
			valid_q[addr.set][alloc_way] <= 1'b1;
		end
	end

endmodule

/* logic/l2_victim_sel.sv */
// Victim way choice for a miss
// A free way is always preferred; a full set falls back to LFSR bits
module l2_victim_sel (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic [l2_pkg::WAYS-1:0]  set_valid,
	input  logic                     alloc,
	output logic [l2_pkg::WAY_W-1:0] victim_way
);
	import l2_pkg::*;

	logic [15:0]      lfsr_q;
	logic [15:0]      lfsr_d;
	logic [WAY_W-1:0] free_way;

	// Lowest way with a clear valid bit, scan from the top down
	always_comb begin
		free_way = '0;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (!set_valid[w]) begin
				free_way = WAY_W'(w);
			end
		end
	end

	// 16-bit xorshift, shifts 7 / 9 / 8
	always_comb begin
		lfsr_d = lfsr_q ^ (lfsr_q << 7);
		lfsr_d = lfsr_d ^ (lfsr_d >> 9);
		lfsr_d = lfsr_d ^ (lfsr_d << 8);
	end

	// Steps once per allocation
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lfsr_q <= LFSR_SEED;
		end else if (alloc) begin
			lfsr_q <= lfsr_d;
		end
	end

	assign victim_way = (&set_valid) ? lfsr_q[WAY_W-1:0] : free_way;

endmodule

/* logic/l2_data_store.sv */
// Line data array, one beat wide, indexed by way, set and beat
// Read is registered; rd_data holds while rd_en is low
// Write and read never happen in the same cycle, so one way select serves both
module l2_data_store (
	input  logic                      clk,
	input  logic [l2_pkg::WAY_W-1:0]  way,
	input  logic                      wr_en,
	input  logic [l2_pkg::SET_W-1:0]  wr_set,
	input  logic [l2_pkg::BEAT_W-1:0] wr_beat,
	input  logic [l2_pkg::DATA_W-1:0] wr_data,
	input  logic                      rd_en,
	input  logic [l2_pkg::SET_W-1:0]  rd_set,
	input  logic [l2_pkg::BEAT_W-1:0] rd_beat,
	output logic [l2_pkg::DATA_W-1:0] rd_data
);
	import l2_pkg::*;

	// 4 x 32 x 16 beats of 64 bits
	logic [DATA_W-1:0] mem [WAYS][SETS][LINE_BEATS];

	// Refill beats land here, full beat always written
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[way][wr_set][wr_beat] <= wr_data;
		end
	end

	// Registered read port
	// Output stays put under upstream back-pressure
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[way][rd_set][rd_beat];
		end
	end

endmodule

/* logic/l2_refill.sv */
// Line refill engine on the downstream AXI4 read port
// Issues one line-aligned INCR burst of LINE_BEATS beats per refill_start
// line_addr must stay stable until refill_done
module l2_refill (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      refill_start,
	input  l2_pkg::l2_addr_t          line_addr,
	input  logic                      mem_ar_ready,
	input  logic                      mem_r_valid,
	input  l2_pkg::axi_r_t            mem_r,
	output logic                      mem_ar_valid,
	output l2_pkg::axi_ar_t           mem_ar,
	output logic                      mem_r_ready,
	output logic                      wr_en,
	output logic [l2_pkg::BEAT_W-1:0] wr_beat,
	output logic [l2_pkg::DATA_W-1:0] wr_data,
	output logic                      refill_done
);
	import l2_pkg::*;

	logic              ar_valid_q;
	logic              busy_q;
	logic [BEAT_W-1:0] beat_q;

	// Line-aligned address, fixed length and INCR
	assign mem_ar.addr  = {line_addr.tag, line_addr.set, {(BEAT_W + OFFS_W){1'b0}}};
	assign mem_ar.len   = 8'(LINE_BEATS - 1);
	assign mem_ar.burst = INCR;
	assign mem_ar_valid = ar_valid_q;

	// Ready for data for the whole refill
	assign mem_r_ready  = busy_q;
	assign wr_en        = mem_r_valid & busy_q;
	assign wr_beat      = beat_q;
	assign wr_data      = mem_r.data;
	assign refill_done  = wr_en & mem_r.last;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ar_valid_q <= 1'b0;
			busy_q     <= 1'b0;
			beat_q     <= '0;
		end else begin
			// AR held until accepted
			if (refill_start) begin
				ar_valid_q <= 1'b1;
			end else if (mem_ar_ready) begin
				ar_valid_q <= 1'b0;
			end
			if (refill_start) begin
				busy_q <= 1'b1;
			end else if (refill_done) begin
				busy_q <= 1'b0;
			end
			// Beat index into the line
			if (refill_start) begin
				beat_q <= '0;
			end else if (wr_en) begin
				beat_q <= beat_q + 1'b1;
			end
		end
	end

endmodule

/* logic/l2_read_resp.sv */
// Upstream R channel sequencer for a hit
// INCR advances the beat (wraps inside the line), FIXED repeats it
// The array read runs one cycle ahead of each accepted beat
module l2_read_resp (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      resp_start,
	input  l2_pkg::axi_ar_t           req,
	input  logic                      up_r_ready,
	input  logic [l2_pkg::DATA_W-1:0] rd_data,
	output logic                      rd_en,
	output logic [l2_pkg::BEAT_W-1:0] rd_beat,
	output logic                      up_r_valid,
	output l2_pkg::axi_r_t            up_r,
	output logic                      resp_done
);
	import l2_pkg::*;

	l2_addr_t          start;
	logic              valid_q;
	logic [7:0]        cnt_q;
	logic [7:0]        len_q;
	axi_burst_e        burst_q;
	logic [BEAT_W-1:0] beat_q;
	logic [BEAT_W-1:0] next_beat;
	logic              r_hs;

	assign start     = req.addr;
	assign r_hs      = valid_q & up_r_ready;
	assign next_beat = (burst_q == INCR) ? beat_q + 1'b1 : beat_q;

	// First read on accept, then one per accepted beat that is not last
	assign rd_en     = resp_start | (r_hs & ~up_r.last);
	assign rd_beat   = resp_start ? start.beat : next_beat;

	assign up_r_valid = valid_q;
	assign up_r.data  = rd_data;
	// OKAY
	assign up_r.resp  = 2'b00;
	assign up_r.last  = (cnt_q == len_q);
	assign resp_done  = r_hs & up_r.last;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
			cnt_q   <= '0;
		end else if (resp_start) begin
			valid_q <= 1'b1;
			cnt_q   <= '0;
		end else if (r_hs) begin
			valid_q <= ~up_r.last;
			cnt_q   <= cnt_q + 8'd1;
		end
	end

	// Burst shape and current beat
	always_ff @(posedge clk) begin
		if (resp_start) begin
			len_q   <= req.len;
			burst_q <= req.burst;
		end
		if (rd_en) begin
			beat_q <= rd_beat;
		end
	end

endmodule

/* logic/l2_cache.sv */
// Read-only set-associative L2 cache with one AXI4 read port up and one down
// One request in flight; an upstream INCR burst must stay inside one line
// RRESP is always OKAY; fence_req must be held until fence_done
module l2_cache (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              up_ar_valid,
	output logic              up_ar_ready,
	input  l2_pkg::axi_ar_t   up_ar,
	output logic              up_r_valid,
	input  logic              up_r_ready,
	output l2_pkg::axi_r_t    up_r,
	output logic              mem_ar_valid,
	input  logic              mem_ar_ready,
	output l2_pkg::axi_ar_t   mem_ar,
	input  logic              mem_r_valid,
	output logic              mem_r_ready,
	input  l2_pkg::axi_r_t    mem_r,
	input  logic              fence_req,
	output logic              fence_done
);
	import l2_pkg::*;

	// Latched request and its address view
	axi_ar_t           req;
	l2_addr_t          req_addr;

	// Controller commands
	logic              alloc;
	logic              refill_start;
	logic              resp_start;
	logic              inval_all;

	// Datapath status
	logic              hit;
	logic [WAY_W-1:0]  hit_way;
	logic [WAY_W-1:0]  victim_way;
	logic [WAYS-1:0]   set_valid;
	logic              refill_done;
	logic              resp_done;

	// Data array ports
	logic              wr_en;
	logic [BEAT_W-1:0] wr_beat;
	logic [DATA_W-1:0] wr_data;
	logic              rd_en;
	logic [BEAT_W-1:0] rd_beat;
	logic [DATA_W-1:0] rd_data;

	assign req_addr = req.addr;

	// Lookup strobe is consumed inside the controller only
	l2_ctrl u_ctrl (
		.clk(clk), .arst_n(arst_n), .up_ar_valid(up_ar_valid), .up_ar(up_ar),
		.fence_req(fence_req), .hit(hit), .refill_done(refill_done),
		.resp_done(resp_done), .up_ar_ready(up_ar_ready), .req(req), .lookup(),
		.alloc(alloc), .refill_start(refill_start), .resp_start(resp_start),
		.inval_all(inval_all), .fence_done(fence_done)
	);

	l2_tag_store u_tag_store (
		.clk(clk), .arst_n(arst_n), .addr(req_addr), .alloc(alloc),
		.alloc_way(victim_way), .inval_all(inval_all), .hit(hit),
		.hit_way(hit_way), .set_valid(set_valid)
	);

	l2_victim_sel u_victim_sel (
		.clk(clk), .arst_n(arst_n), .set_valid(set_valid), .alloc(alloc),
		.victim_way(victim_way)
	);

	// Allocated way already hits during refill, so hit_way steers both ports
	l2_data_store u_data_store (
		.clk(clk), .way(hit_way), .wr_en(wr_en), .wr_set(req_addr.set),
		.wr_beat(wr_beat), .wr_data(wr_data), .rd_en(rd_en),
		.rd_set(req_addr.set), .rd_beat(rd_beat), .rd_data(rd_data)
	);

	l2_refill u_refill (
		.clk(clk), .arst_n(arst_n), .refill_start(refill_start), .line_addr(req_addr),
		.mem_ar_ready(mem_ar_ready), .mem_r_valid(mem_r_valid), .mem_r(mem_r),
		.mem_ar_valid(mem_ar_valid), .mem_ar(mem_ar), .mem_r_ready(mem_r_ready),
		.wr_en(wr_en), .wr_beat(wr_beat), .wr_data(wr_data), .refill_done(refill_done)
	);

	l2_read_resp u_read_resp (
		.clk(clk), .arst_n(arst_n), .resp_start(resp_start), .req(req),
		.up_r_ready(up_r_ready), .rd_data(rd_data), .rd_en(rd_en), .rd_beat(rd_beat),
		.up_r_valid(up_r_valid), .up_r(up_r), .resp_done(resp_done)
	);

endmodule

/* dv/l2_mem_model.sv */
// AXI4 read memory behind the refill port with {addr, ~addr} at each beat address
// INCR bursts only, one burst at a time
// Ready and valid gaps come from a fixed-seed xorshift
module l2_mem_model (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            ar_valid,
	output logic            ar_ready,
	input  l2_pkg::axi_ar_t ar,
	output logic            r_valid,
	input  logic            r_ready,
	output l2_pkg::axi_r_t  r,
	output int              refill_count
);
	timeunit 1ns;
	timeprecision 1ps;
	import l2_pkg::*;

	localparam logic [31:0] SEED = 32'h2a61c5bc;

	logic              busy;
	logic              taken;
	logic [ADDR_W-1:0] base;
	logic [7:0]        len_q;
	logic [7:0]        beat_n;
	logic [31:0]       rng;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Handshakes seen on the rising edge
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy         <= 1'b0;
			taken        <= 1'b0;
			beat_n       <= '0;
			len_q        <= '0;
			base         <= '0;
			refill_count <= 0;
		end else begin
			taken <= r_valid && r_ready;
			if (ar_valid && ar_ready) begin
				busy         <= 1'b1;
				base         <= ar.addr;
				len_q        <= ar.len;
				beat_n       <= '0;
				refill_count <= refill_count + 1;
			end
			if (r_valid && r_ready) begin
				beat_n <= beat_n + 8'd1;
				// Burst over after the last beat
				if (r.last) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// Outputs only move on the falling edge
	// Busy is low in reset, so no beat leaves before the first AR
	initial begin
		ar_ready = 1'b0;
		r_valid  = 1'b0;
		r        = '0;
		rng      = SEED;
		forever begin
			@(negedge clk);
			rng      = xorshift32(rng);
			ar_ready = !busy && rng[0];
			// A beat that was not taken yet stays on the bus
			if (!(r_valid && !taken)) begin
				r_valid = busy && (rng[2:1] != 2'b00);
				r.data  = {base + (ADDR_W'(beat_n) << OFFS_W),
					~(base + (ADDR_W'(beat_n) << OFFS_W))};
				r.resp  = 2'b00;
				r.last  = (beat_n == len_q);
			end
		end
	end

endmodule

/* dv/tb_l2_cache.sv */
// Testbench for the L2 read cache covering miss and hit, FIXED, back-pressure, way fill and fence
// Expected beats rebuilt from the memory pattern; refills counted at the memory model
module tb_l2_cache;
	timeunit 1ns;
	timeprecision 1ps;
	import l2_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RST_CYCLES = 16;
	localparam int N_REQ      = 18;
	localparam int TIMEOUT_NS = (N_REQ * 200 + RST_CYCLES) * CLK_PERIOD;

	logic    clk;
	logic    arst_n;
	logic    up_ar_valid;
	logic    up_ar_ready;
	axi_ar_t up_ar;
	logic    up_r_valid;
	logic    up_r_ready;
	axi_r_t  up_r;
	logic    mem_ar_valid;
	logic    mem_ar_ready;
	axi_ar_t mem_ar;
	logic    mem_r_valid;
	logic    mem_r_ready;
	axi_r_t  mem_r;
	logic    fence_req;
	logic    fence_done;
	int      refill_count;

	// Accepted requests still waiting for their last beat
	axi_ar_t     exp_q[$];
	int          issued = 0;
	int          done_cnt = 0;
	int          beat_idx = 0;
	int          fence_cnt = 0;
	int          base_cnt;
	logic        bp_on;
	logic [31:0] rng;

	l2_cache UUT (.*);

	l2_mem_model mem (
		.clk(clk), .arst_n(arst_n), .ar_valid(mem_ar_valid), .ar_ready(mem_ar_ready),
		.ar(mem_ar), .r_valid(mem_r_valid), .r_ready(mem_r_ready), .r(mem_r),
		.refill_count(refill_count)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	function automatic logic [31:0] next_rand(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Reference memory pattern at a beat-aligned address
	function automatic logic [63:0] mem_word(input logic [31:0] addr);
		logic [31:0] a;
		a = {addr[31:3], 3'b000};
		return {a, ~a};
	endfunction

	task automatic stop_fail(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			stop_fail($sformatf("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp));
		end
	endtask

	// One request held until accepted, then a wait for its last beat
	task automatic read_burst(input logic [31:0] addr, input logic [7:0] len,
			input axi_burst_e burst);
		@(negedge clk);
		up_ar_valid = 1'b1;
		up_ar.addr  = addr;
		up_ar.len   = len;
		up_ar.burst = burst;
		@(posedge clk);
		while (!up_ar_ready) begin
			@(posedge clk);
		end
		exp_q.push_back(up_ar);
		issued++;
		@(negedge clk);
		up_ar_valid = 1'b0;
		wait (done_cnt == issued);
	endtask

	function automatic logic [31:0] way_addr(input int t);
		// Tag 0x100 + t in set 5
		return 32'h0010_0280 + 32'(t) * 32'h1000;
	endfunction

	// Ready with optional random gaps
	always @(negedge clk) begin
		rng = next_rand(rng);
		up_r_ready = !bp_on || rng[0];
	end

	// Monitor checks every accepted beat against the reference
	always @(posedge clk) begin
		axi_ar_t     cur;
		logic [31:0] a;
		if (arst_n && up_r_valid && up_r_ready) begin
			if (exp_q.size() == 0) begin
				stop_fail("A read beat arrived with no request outstanding");
			end else begin
				cur = exp_q[0];
				a = {cur.addr[31:3], 3'b000};
				if (cur.burst == INCR) begin
					a = a + (32'(beat_idx) << OFFS_W);
				end
				check_eq(up_r.data, mem_word(a), "R data");
				check_eq(64'(up_r.last), 64'(beat_idx == 32'(cur.len)), "R last");
				check_eq(64'(up_r.resp), 64'd0, "R resp");
				if (up_r.last) begin
					void'(exp_q.pop_front());
					beat_idx = 0;
					done_cnt++;
				end else begin
					beat_idx++;
				end
			end
		end
	end

	// Refill request is the pending line, 16 beats, INCR
	always @(posedge clk) begin
		if (arst_n && mem_ar_valid && mem_ar_ready) begin
			check_eq(64'(mem_ar.addr), 64'({up_ar.addr[31:7], 7'd0}), "refill AR addr");
			check_eq(64'(mem_ar.len), 64'd15, "refill AR len");
			check_eq(64'(mem_ar.burst), 64'(INCR), "refill AR burst");
		end
	end

	always @(posedge clk) begin
		if (fence_done) begin
			fence_cnt <= fence_cnt + 1;
		end
	end

	initial begin
		#(TIMEOUT_NS);
		stop_fail("Timeout: the DUT stopped answering before all requests finished");
	end

	initial begin
		arst_n      = 1'b0;
		up_ar_valid = 1'b0;
		up_ar       = '0;
		up_r_ready  = 1'b0;
		fence_req   = 1'b0;
		bp_on       = 1'b0;
		rng         = 32'h2a61c5bc;
		repeat (RST_CYCLES) @(negedge clk);
		arst_n = 1'b1;

		// Cold miss, repeat hit, partial hit in the same line
		base_cnt = refill_count;
		read_burst(32'h0000_1000, 8'd15, INCR);
		check_eq(64'(refill_count), 64'(base_cnt + 1), "refills after cold miss");
		read_burst(32'h0000_1000, 8'd15, INCR);
		read_burst(32'h0000_1040, 8'd3, INCR);
		check_eq(64'(refill_count), 64'(base_cnt + 1), "refills after hits");

		// FIXED on a hit line and on a new line
		base_cnt = refill_count;
		read_burst(32'h0000_1018, 8'd7, FIXED);
		read_burst(32'h0000_2008, 8'd4, FIXED);
		check_eq(64'(refill_count), 64'(base_cnt + 1), "refills after FIXED");

		// Upstream back-pressure
		bp_on = 1'b1;
		read_burst(32'h0000_1000, 8'd15, INCR);
		read_burst(32'h0000_2010, 8'd5, INCR);
		bp_on = 1'b0;
		check_eq(64'(refill_count), 64'(base_cnt + 1), "refills under back-pressure");

		// Fill all four ways of set 5, reread, then evict one
		base_cnt = refill_count;
		for (int t = 0; t < WAYS; t++) begin
			read_burst(way_addr(t), 8'd15, INCR);
		end
		check_eq(64'(refill_count), 64'(base_cnt + 4), "refills filling set");
		for (int t = 0; t < WAYS; t++) begin
			read_burst(way_addr(t), 8'd15, INCR);
		end
		check_eq(64'(refill_count), 64'(base_cnt + 4), "refills rereading set");
		read_burst(way_addr(4), 8'd15, INCR);
		check_eq(64'(refill_count), 64'(base_cnt + 5), "refills after fifth tag");

		// Fence and then everything misses again
		@(negedge clk);
		fence_req = 1'b1;
		@(posedge clk);
		while (!fence_done) begin
			@(posedge clk);
		end
		@(negedge clk);
		fence_req = 1'b0;
		repeat (4) @(negedge clk);
		check_eq(64'(fence_cnt), 64'd1, "fence_done pulses");
		base_cnt = refill_count;
		read_burst(32'h0000_1000, 8'd15, INCR);
		read_burst(way_addr(4), 8'd15, INCR);
		check_eq(64'(refill_count), 64'(base_cnt + 2), "refills after fence");

		$display("=== PASS ===");
		$finish;
	end

endmodule

/* tb.f */
logic/l2_pkg.sv
logic/l2_ctrl.sv
logic/l2_tag_store.sv
logic/l2_victim_sel.sv
logic/l2_data_store.sv
logic/l2_refill.sv
logic/l2_read_resp.sv
logic/l2_cache.sv
dv/l2_mem_model.sv
dv/tb_l2_cache.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_l2_cache
OBJ_DIR   ?= obj_dir
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
